/* bench/mic_playback_trace.txt */
// One line per frame: microphone word, source code, expected line_out
// Source codes: 0 mute, 1 raw, 2 filtered, 3 echo, 4 tone
1000 0 0000
1000 2 FFF0
1000 2 FFD0
1000 4 3800
1000 2 0050
1000 3 0000
1000 2 03B0
1000 1 1000
1000 2 0990
1000 3 FFF0
1000 2 0E70
1000 3 FFD0
1000 2 1030
1000 3 0190
1000 2 1010
8001 2 1000
8001 1 8001
0000 3 0C50
7FFF 4 6780
7FFF 3 0FB0
7FFF 1 7FFF
7FFF 3 1030
7FFF 0 0000
7FFF 3 1000
7FFF 4 2080
7FFF 1 7FFF
7FFF 4 0480
0000 1 7FFF
8001 0 0000
8001 4 D980
7FFF 2 7FFF
7FFF 1 7FFF
0000 4 B300
8000 0 0000
8000 1 8000
8000 4 9500
8000 1 8000
8000 0 0000
8000 4 8380
8000 1 8000
8000 4 8080
8000 1 8000
0000 4 8400
7FFF 1 0000
7FFF 0 0000
1234 2 8000
ABCD 1 1234
0001 1 ABCD

/* mic_playback.f */
design/audio_pkg.sv
design/i2s_pkg.sv
design/i2s_receiver.sv
design/anti_alias_fir.sv
design/echo_delay.sv
design/tone_generator.sv
design/pdm_modulator.sv
design/mic_playback_top.sv
bench/mic_playback_checker.sv
bench/mic_playback_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= mic_playback_tb
FILELIST  ?= mic_playback.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)

/* bench/mic_playback_tb.sv */
`timescale 1ns/1ps

module mic_playback_tb import audio_pkg::*, i2s_pkg::*; ();

  localparam int          N_LINES        = 48;
  localparam int unsigned TIMEOUT_CYCLES = (N_LINES + 4) * FRAME_CLKS;
  localparam logic [31:0] SEED           = 32'h852129ed;

  logic        audio_clk;
  logic        rst_n;
  logic        mic_data;
  logic        mic_bclk;
  logic        mic_lrcl;
  src_sel_t    source_sel;
  logic [1:0]  spk_enable;
  logic        spk_l;
  logic        spk_r;
  sample_t     line_out;
  logic        line_valid;

  logic [15:0] trace_mem [3*N_LINES];  // Word, source code, expected line_out
  logic [15:0] mic_word [N_LINES];
  logic [15:0] expected [N_LINES];
  logic [31:0] lcg_state;
  int unsigned cycles = 0;
  int          fall_cnt;
  int          errors;
  int          checks;
  logic        done;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Speaker enables per frame, gating one side or both for a while
  function automatic logic [1:0] enable_for_frame(input int frame);
    case (frame)
      21, 22:  return 2'b01;
      27, 28:  return 2'b10;
      36, 37:  return 2'b00;
      default: return 2'b11;
    endcase
  endfunction

  mic_playback_top #(
    .DELAY_SAMPLES(8),
    .PHASE_INCR   (32'h04B17E4B)
  ) dut (
    .audio_clk, .rst_n, .mic_data, .mic_bclk, .mic_lrcl, .source_sel,
    .spk_enable, .spk_l, .spk_r, .line_out, .line_valid
  );

  mic_playback_checker #(.N_LINES(N_LINES)) u_checker (
    .audio_clk, .rst_n, .line_out, .line_valid, .spk_l, .spk_r, .spk_enable,
    .mic_bclk, .mic_lrcl, .expected, .errors, .checks, .done
  );

  always #50 audio_clk = ~audio_clk;

  always @(posedge audio_clk) cycles <= cycles + 1;

  // Each falling bit clock starts a new bit; count them to find frame and bit
  always @(negedge mic_bclk) begin
    int frame;
    int bit_pos;
    if (rst_n) begin
      fall_cnt = fall_cnt + 1;
      frame    = fall_cnt / FRAME_BITS;
      bit_pos  = fall_cnt % FRAME_BITS;
      #5;
      lcg_state = lcg_next(lcg_state);
      if (bit_pos >= DATA_MSB_BIT && bit_pos < DATA_MSB_BIT + SAMPLE_BITS &&
          frame < N_LINES) begin
        mic_data = mic_word[frame][15 - (bit_pos - DATA_MSB_BIT)];  // MSB first
      end else begin
        mic_data = lcg_state[31];  // Noise outside the data window
      end
      if (bit_pos == FRAME_BITS / 2 && frame < N_LINES) begin
        source_sel = src_sel_t'(trace_mem[3*frame+1][2:0]);
        spk_enable = enable_for_frame(frame);
      end
    end
  end

  initial begin
    audio_clk  = 1'b0;
    rst_n      = 1'b0;
    mic_data   = 1'b0;
    source_sel = src_mute;
    spk_enable = 2'b11;
    lcg_state  = SEED;
    fall_cnt   = 0;
    $readmemh("bench/mic_playback_trace.txt", trace_mem);
    for (int i = 0; i < N_LINES; i++) begin
      mic_word[i] = trace_mem[3*i];
      expected[i] = trace_mem[3*i+2];
    end
    repeat (3) @(posedge audio_clk);
    #5 rst_n = 1'b1;
    while (!done && cycles < TIMEOUT_CYCLES) begin
      @(posedge audio_clk);
    end
    if (done) begin
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
        $display("test passed");
      end else begin
        $display("test failed");
      end
    end else begin
      $display("Timeout after %0d cycles, line_valid did not cover the whole trace",
               cycles);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("test failed");
    end
    $finish;
  end

endmodule

/* bench/mic_playback_checker.sv */
`timescale 1ns/1ps

module mic_playback_checker import audio_pkg::*; #(
  parameter int N_LINES = 48
) (
  input  logic        audio_clk,
  input  logic        rst_n,
  input  sample_t     line_out,
  input  logic        line_valid,
  input  logic        spk_l,
  input  logic        spk_r,
  input  logic [1:0]  spk_enable,
  input  logic        mic_bclk,
  input  logic        mic_lrcl,
  input  logic [15:0] expected [N_LINES],
  output int          errors,
  output int          checks,
  output logic        done
);

  localparam int BCLK_PERIOD = 32;
  localparam int LRCL_HALF   = FRAME_CLKS / 2;  // 32 bit clocks per channel

  int      pulses = 0;
  int      since_pulse = 0;
  int      since_bclk = 0;
  int      since_lrcl = 0;
  int      ones_l = 0;
  int      ones_r = 0;
  int      density_checks = 0;
  logic    bclk_prev = 1'b0;
  logic    bclk_seen = 1'b0;
  logic    lrcl_prev = 1'b0;
  logic    lrcl_seen = 1'b0;
  logic    en_l_all = 1'b1;
  logic    en_r_all = 1'b1;
  sample_t win_level = '0;  // Level expected during the current frame

  // Zero level gives half ones plus one stale bit at the window start
  function automatic bit density_ok(input int ones);
    return (ones >= FRAME_CLKS / 2 - 1) && (ones <= FRAME_CLKS / 2 + 1);
  endfunction

  initial begin
    errors = 0;
    checks = 0;
    done   = 1'b0;
  end

  always @(posedge audio_clk) begin
    if (!rst_n) begin
      if (line_valid) begin
        errors++;
        $display("FAIL t=%0t line_valid during reset expected 0 actual %b",
                 $time, line_valid);
      end
    end else begin
      if (mic_bclk && !bclk_prev) begin
        if (bclk_seen && since_bclk != BCLK_PERIOD) begin
          errors++;
          $display("FAIL t=%0t mic_bclk period expected %0d actual %0d",
                   $time, BCLK_PERIOD, since_bclk);
        end
        bclk_seen  = 1'b1;
        since_bclk = 0;
      end
      since_bclk++;

      if (mic_lrcl !== lrcl_prev) begin
        if (lrcl_seen && since_lrcl != LRCL_HALF) begin
          errors++;
          $display("FAIL t=%0t mic_lrcl half period expected %0d actual %0d",
                   $time, LRCL_HALF, since_lrcl);
        end
        lrcl_seen  = 1'b1;
        since_lrcl = 0;
      end
      since_lrcl++;

      if ((!spk_enable[0] && spk_l) || (!spk_enable[1] && spk_r)) begin
        errors++;
        $display("FAIL t=%0t spk_l/spk_r expected 0/0 actual %b/%b", $time, spk_l, spk_r);
      end

      if (line_valid) begin
        // Frame has just started, so the left half-frame is on
        if (mic_lrcl !== 1'b0) begin
          errors++;
          $display("FAIL t=%0t mic_lrcl at frame start expected 0 actual %b",
                   $time, mic_lrcl);
        end
        if (pulses > 0) begin
          checks++;
          if (since_pulse != FRAME_CLKS) begin
            errors++;
            $display("FAIL t=%0t line_valid interval expected %0d actual %0d",
                     $time, FRAME_CLKS, since_pulse);
          end
          if (win_level == 0 && en_l_all && en_r_all) begin
            density_checks++;
            if (!density_ok(ones_l) || !density_ok(ones_r)) begin
              errors++;
              $display("FAIL t=%0t spk ones per frame expected %0d actual %0d/%0d",
                       $time, FRAME_CLKS / 2, ones_l, ones_r);
            end
          end
        end
        if (pulses >= 1 && pulses <= N_LINES) begin
          checks++;
          if (line_out !== sample_t'(expected[pulses-1])) begin
            errors++;
            $display("FAIL t=%0t line_out expected %h actual %h",
                     $time, expected[pulses-1], line_out);
          end
          win_level = sample_t'(expected[pulses-1]);
        end
        pulses++;
        if (pulses == N_LINES + 1) begin
          if (density_checks == 0) begin
            errors++;
            $display("No silent frame with both speakers enabled was measured");
          end
          done <= 1'b1;
        end
        since_pulse = 0;
        ones_l      = 0;
        ones_r      = 0;
        en_l_all    = 1'b1;
        en_r_all    = 1'b1;
      end
      since_pulse++;
      ones_l   += int'(spk_l);
      ones_r   += int'(spk_r);
      en_l_all &= spk_enable[0];
      en_r_all &= spk_enable[1];
    end
    bclk_prev = mic_bclk;
    lrcl_prev = mic_lrcl;
  end

endmodule

/* design/mic_playback_top.sv */
`timescale 1ns/1ps

module mic_playback_top import audio_pkg::*; #(
  parameter int          DELAY_SAMPLES = 48000,
  parameter logic [31:0] PHASE_INCR    = 32'h04B1_7E4B
) (
  input  logic     audio_clk,
  input  logic     rst_n,
  input  logic     mic_data,
  output logic     mic_bclk,
  output logic     mic_lrcl,
  input  src_sel_t source_sel,
  input  logic [1:0] spk_enable,
  output logic     spk_l,
  output logic     spk_r,
  output sample_t  line_out,
  output logic     line_valid
);

  localparam int FCNT_W = $clog2(FRAME_CLKS);

  logic [FCNT_W-1:0] frame_cnt;
  logic              sample_tick;
  sample_t           raw_sample;
  sample_t           raw_hold;
  sample_t           filt_sample;
  sample_t           echo_sample;
  sample_t           tone_sample;
  logic              raw_valid;
  logic              filt_valid;
  logic              pdm_bit;

  // 48 kHz strobe, also the start of every I2S frame
  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      frame_cnt <= '0;
    end else begin
      frame_cnt <= (frame_cnt == FCNT_W'(FRAME_CLKS - 1)) ? '0 : frame_cnt + 1'b1;
    end
  end

  assign sample_tick = (frame_cnt == '0);

  i2s_receiver u_i2s (
    .audio_clk, .rst_n, .sample_tick, .mic_data,
    .mic_bclk, .mic_lrcl, .raw_sample, .raw_valid
  );

  anti_alias_fir u_fir (
    .audio_clk, .rst_n, .raw_sample, .raw_valid, .filt_sample, .filt_valid
  );

  echo_delay #(.DELAY_SAMPLES(DELAY_SAMPLES)) u_echo (
    .audio_clk, .rst_n, .filt_sample, .filt_valid, .echo_sample
  );

  tone_generator #(.PHASE_INCR(PHASE_INCR)) u_tone (
    .audio_clk, .rst_n, .sample_tick, .tone_sample
  );

  pdm_modulator u_pdm (.audio_clk, .rst_n, .level(line_out), .pdm(pdm_bit));

  // Source switches only on the tick, so a frame never mixes two sources
  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      raw_hold   <= '0;
      line_out   <= '0;
      line_valid <= 1'b0;
    end else begin
      if (raw_valid) raw_hold <= raw_sample;
      line_valid <= sample_tick;
      if (sample_tick) begin
        case (source_sel)
          src_raw:      line_out <= raw_hold;
          src_filtered: line_out <= filt_sample;
          src_echo:     line_out <= echo_sample;
          src_tone:     line_out <= tone_sample;
          default:      line_out <= '0;  // Mute and unused codes
        endcase
      end
    end
  end

  assign spk_l = pdm_bit & spk_enable[0];
  assign spk_r = pdm_bit & spk_enable[1];

  // Filter latency is fixed, relied on by the echo and the selector
  a_fir_latency : assert property (
    @(posedge audio_clk) disable iff (!rst_n) raw_valid |-> ##(FIR_TAPS + 2) filt_valid
  );

endmodule

/* design/pdm_modulator.sv */
`timescale 1ns/1ps

module pdm_modulator import audio_pkg::*; (
  input  logic    audio_clk,
  input  logic    rst_n,
  input  sample_t level,
  output logic    pdm
);

  logic [15:0] offset_level;
  logic [15:0] err_acc;
  logic [16:0] sum;

  // Flipping the sign bit adds 32768, so silence maps to mid-scale
  assign offset_level = {~level[15], level[14:0]};

  assign sum = {1'b0, err_acc} + {1'b0, offset_level};

  // Carry out is the output bit, remainder is kept as the error
  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      err_acc <= '0;
      pdm     <= 1'b0;
    end else begin
      err_acc <= sum[15:0];
      pdm     <= sum[16];
    end
  end

endmodule

/* design/tone_generator.sv */
`timescale 1ns/1ps

module tone_generator import audio_pkg::*; #(
  parameter logic [31:0] PHASE_INCR = 32'h04B1_7E4B  // About 880 Hz at 48 kHz
) (
  input  logic    audio_clk,
  input  logic    rst_n,
  input  logic    sample_tick,
  output sample_t tone_sample
);

  // First quarter of a sine, sampled at bin centres, 8-bit magnitude
  localparam logic [7:0] QUARTER_SINE [64] = '{
      8'd3,   8'd9,  8'd16,  8'd22,  8'd28,  8'd34,  8'd41,  8'd47,
     8'd53,  8'd59,  8'd65,  8'd71,  8'd77,  8'd83,  8'd89,  8'd95,
    8'd100, 8'd106, 8'd112, 8'd117, 8'd123, 8'd128, 8'd134, 8'd139,
    8'd144, 8'd149, 8'd154, 8'd159, 8'd164, 8'd169, 8'd174, 8'd178,
    8'd183, 8'd187, 8'd191, 8'd195, 8'd199, 8'd203, 8'd207, 8'd210,
    8'd214, 8'd217, 8'd220, 8'd223, 8'd226, 8'd229, 8'd232, 8'd234,
    8'd237, 8'd239, 8'd241, 8'd243, 8'd245, 8'd247, 8'd248, 8'd249,
    8'd251, 8'd252, 8'd253, 8'd253, 8'd254, 8'd255, 8'd255, 8'd255
  };

  logic [31:0] phase;
  logic [1:0]  quadrant;
  logic [5:0]  rom_idx;
  logic [7:0]  magnitude;
  sample_t     scaled;

  assign quadrant = phase[31:30];

  // Odd quadrants run the table backwards
  assign rom_idx   = quadrant[0] ? ~phase[29:24] : phase[29:24];
  assign magnitude = QUARTER_SINE[rom_idx];
  assign scaled    = sample_t'({1'b0, magnitude, 7'b0});  // Peak just under full scale

  // Second half of the cycle is the negative lobe
  assign tone_sample = quadrant[1] ? -scaled : scaled;

  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      phase <= '0;
    end else if (sample_tick) begin
      phase <= phase + PHASE_INCR;  // Wraps once per tone period
    end
  end

endmodule

/* design/echo_delay.sv */
`timescale 1ns/1ps

module echo_delay import audio_pkg::*; #(
  parameter int DELAY_SAMPLES = 48000
) (
  input  logic    audio_clk,
  input  logic    rst_n,
  input  sample_t filt_sample,
  input  logic    filt_valid,
  output sample_t echo_sample
);

  localparam int PTR_W = (DELAY_SAMPLES > 1) ? $clog2(DELAY_SAMPLES) : 1;

  sample_t          mem [DELAY_SAMPLES];
  logic [PTR_W-1:0] wr_ptr;
  logic             filled;  // Set once every entry has been written

  always_ff @(posedge audio_clk) begin
    if (filt_valid) begin
      mem[wr_ptr] <= filt_sample;
    end
  end

  // Read-before-write at the same slot gives the oldest sample
  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr      <= '0;
      filled      <= 1'b0;
      echo_sample <= '0;
    end else if (filt_valid) begin
      echo_sample <= filled ? mem[wr_ptr] : '0;
      if (wr_ptr == PTR_W'(DELAY_SAMPLES - 1)) begin
        wr_ptr <= '0;
        filled <= 1'b1;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  a_ptr_in_range : assert property (
    @(posedge audio_clk) disable iff (!rst_n) wr_ptr < DELAY_SAMPLES
  );

endmodule

/* design/anti_alias_fir.sv */
`timescale 1ns/1ps

module anti_alias_fir import audio_pkg::*; (
  input  logic    audio_clk,
  input  logic    rst_n,
  input  sample_t raw_sample,
  input  logic    raw_valid,
  output sample_t filt_sample,
  output logic    filt_valid
);

  localparam int IDX_W = $clog2(FIR_TAPS);
  localparam int ACC_W = 32 + IDX_W;  // Room for FIR_TAPS full-scale products

  localparam logic signed [ACC_W-1:0] ROUND_HALF = ACC_W'(1) <<< 14;

  sample_t                   hist [FIR_TAPS];  // hist[0] is the newest sample
  logic [IDX_W-1:0]          tap_idx;
  logic                      busy;
  logic                      finish;
  logic signed [ACC_W-1:0]   acc;
  logic signed [31:0]        product;
  logic signed [ACC_W-1:0]   rounded;
  sample_t                   sat_value;

  // One multiplier shared by all taps
  assign product = fir_coef[tap_idx] * hist[tap_idx];

  assign rounded = (acc + ROUND_HALF) >>> 15;

  always_comb begin
    if (rounded > 32767) begin
      sat_value = 16'sh7fff;
    end else if (rounded < -32768) begin
      sat_value = -16'sh8000;
    end else begin
      sat_value = rounded[15:0];
    end
  end

  // History starts from silence so early outputs are defined
  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < FIR_TAPS; i++) begin
        hist[i] <= '0;
      end
    end else if (raw_valid) begin
      hist[0] <= raw_sample;
      for (int i = 1; i < FIR_TAPS; i++) begin
        hist[i] <= hist[i-1];
      end
    end
  end

  // 1 cycle load, 15 cycles MAC, 1 cycle round
  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      tap_idx    <= '0;
      busy       <= 1'b0;
      finish     <= 1'b0;
      acc        <= '0;
      filt_valid <= 1'b0;
    end else begin
      filt_valid <= finish;
      finish     <= 1'b0;
      if (raw_valid) begin
        tap_idx <= '0;
        acc     <= '0;
        busy    <= 1'b1;
      end else if (busy) begin
        acc <= acc + product;
        if (tap_idx == IDX_W'(FIR_TAPS - 1)) begin
          busy   <= 1'b0;
          finish <= 1'b1;
        end else begin
          tap_idx <= tap_idx + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge audio_clk) begin
    if (finish) begin
      filt_sample <= sat_value;
    end
  end

  // Receiver spacing must leave the MAC idle before the next sample
  a_no_overrun : assert property (
    @(posedge audio_clk) disable iff (!rst_n) raw_valid |-> !busy && !finish
  );

endmodule

/* design/i2s_receiver.sv */
`timescale 1ns/1ps

module i2s_receiver import audio_pkg::*, i2s_pkg::*; (
  input  logic    audio_clk,
  input  logic    rst_n,
  input  logic    sample_tick,
  input  logic    mic_data,
  output logic    mic_bclk,
  output logic    mic_lrcl,
  output sample_t raw_sample,
  output logic    raw_valid
);

  localparam int BIT_W = $clog2(BCLK_DIV);
  localparam int CNT_W = $clog2(BCLK_DIV * FRAME_BITS);
  localparam int LAST_DATA_BIT = DATA_MSB_BIT + SAMPLE_BITS - 1;

  logic [CNT_W-1:0]       frame_pos;
  logic [BIT_W-1:0]       bit_phase;
  logic [CNT_W-BIT_W-1:0] bit_idx;
  logic [SAMPLE_BITS-1:0] shift_reg;
  logic                   capture;
  logic                   frame_seen;

  assign bit_phase = frame_pos[BIT_W-1:0];
  assign bit_idx   = frame_pos[CNT_W-1:BIT_W];

  // Both clocks come straight from counter flops
  assign mic_bclk = frame_pos[BIT_W-1];  // Low during the first half of a bit
  assign mic_lrcl = frame_pos[CNT_W-1];  // Low for the left half-frame

  // Rising bit clock edge inside the left-channel data window
  assign capture = (bit_phase == BIT_W'(BCLK_DIV / 2)) &&
                   (bit_idx >= DATA_MSB_BIT) &&
                   (bit_idx <= LAST_DATA_BIT);

  // Position within the frame, locked to the sample tick
  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      frame_pos <= '0;
    end else if (sample_tick) begin
      frame_pos <= CNT_W'(1);  // Tick cycle is position zero
    end else begin
      frame_pos <= frame_pos + 1'b1;
    end
  end

  always_ff @(posedge audio_clk) begin
    if (capture) begin
      shift_reg <= {shift_reg[SAMPLE_BITS-2:0], mic_data};  // MSB first
    end
    if (sample_tick) begin
      raw_sample <= sample_t'(shift_reg);
    end
  end

  // No word is presented until one whole frame has been shifted in
  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      frame_seen <= 1'b0;
      raw_valid  <= 1'b0;
    end else begin
      raw_valid <= sample_tick && frame_seen;
      if (sample_tick) begin
        frame_seen <= 1'b1;
      end
    end
  end

  // The tick from the top must be a single-cycle strobe
  a_raw_valid_single : assert property (
    @(posedge audio_clk) disable iff (!rst_n) raw_valid |=> !raw_valid
  );

endmodule

/* design/i2s_pkg.sv */
package i2s_pkg;

  // Audio clocks per bit clock period, high half then low half
  localparam int unsigned BCLK_DIV = 32;

  // Bit clocks per word clock period, left and right halves
  localparam int unsigned FRAME_BITS = 64;

  // Data MSB follows the falling word clock by one bit clock
  localparam int unsigned DATA_MSB_BIT = 1;

  // Upper bits kept from the 24-bit microphone word
  localparam int unsigned SAMPLE_BITS = 16;

endpackage

/* design/audio_pkg.sv */
package audio_pkg;

  // Signed PCM sample carried through the whole audio path
  typedef logic signed [15:0] sample_t;

  // Source feeding the line output and the speakers
  typedef enum logic [2:0] {
    src_mute     = 3'd0,
    src_raw      = 3'd1,
    src_filtered = 3'd2,
    src_echo     = 3'd3,
    src_tone     = 3'd4
  } src_sel_t;

  localparam int unsigned FRAME_CLKS = 2048;  // 98.3 MHz / 48 kHz

  localparam int unsigned FIR_TAPS = 15;

  // Low-pass taps, symmetric, unity DC gain in Q15
  localparam sample_t fir_coef [FIR_TAPS] = '{
    -16'sd128,  -16'sd256,     16'sd0,  16'sd1024,
     16'sd2560,  16'sd4352,  16'sd5632,  16'sd6400,
     16'sd5632,  16'sd4352,  16'sd2560,  16'sd1024,
        16'sd0,  -16'sd256,  -16'sd128
  };

  // Total of all taps is 32768, so the output is the weighted sum
  // shifted right by 15

endpackage
